/* verilog/iwdg_reg_pkg.sv */
package iwdg_reg_pkg;

  // Key register width, also the width of the bus data path.
  localparam int KEY_W = 16;
  // Reload register and downcounter width.
  localparam int RLR_W = 12;
  // Prescale code width.
  localparam int PR_W = 3;
  // Status register width.
  localparam int ST_W = 2;

  // Key values understood by the watchdog.
  // Any other value written to the key register is stored but has no effect.
  typedef enum logic [KEY_W-1:0] {
    KEY_IDLE   = 16'h0000,
    KEY_COUNT  = 16'hCCCC,
    KEY_RELOAD = 16'hAAAA,
    KEY_ACCESS = 16'h5555
  } iwdg_key_e;

  // Prescale codes.
  // The counter clock is iwdg_clk divided by 4 shifted left by the code.
  // Code 7 has no name and is refused by the register file.
  typedef enum logic [PR_W-1:0] {
    PR_DIV4   = 3'd0,
    PR_DIV8   = 3'd1,
    PR_DIV16  = 3'd2,
    PR_DIV32  = 3'd3,
    PR_DIV64  = 3'd4,
    PR_DIV128 = 3'd5,
    PR_DIV256 = 3'd6
  } pr_code_e;

  // Values after reset.
  localparam logic [RLR_W-1:0] RLR_RESET = 12'hFFF;
  localparam pr_code_e PR_RESET = PR_DIV4;

  // Register offsets from the slave base address.
  localparam logic [31:0] KR_OFS  = 32'h0000_0000;
  localparam logic [31:0] PR_OFS  = 32'h0000_0004;
  localparam logic [31:0] RLR_OFS = 32'h0000_0008;
  localparam logic [31:0] ST_OFS  = 32'h0000_000C;

endpackage

/* verilog/iwdg_link_pkg.sv */
package iwdg_link_pkg;

  // Operation carried in the top bit of a command word.
  typedef enum logic {
    LINK_RD = 1'b0,
    LINK_WR = 1'b1
  } link_op_e;

  // Register select field of a command word.
  typedef enum logic [1:0] {
    SEL_KR  = 2'b00,
    SEL_RLR = 2'b01,
    SEL_PR  = 2'b10,
    SEL_ST  = 2'b11
  } reg_sel_e;

  // Command word is {op, sel, payload[15:0]}.
  localparam int CMD_W = 19;
  // Bit position of the opcode.
  localparam int CMD_OP_BIT = 18;
  // Lowest bit of the select field.
  localparam int CMD_SEL_LSB = 16;

  // Response word carries read data, or 1 as a write completion.
  localparam int RSP_W = 16;

  // Bus slave states.
  typedef enum logic [1:0] {
    BUS_IDLE  = 2'b00,
    BUS_ISSUE = 2'b01,
    BUS_WAIT  = 2'b10
  } bus_state_e;

endpackage

/* verilog/iwdg_cdc_fifo.sv */
`timescale 1ns/100ps

module iwdg_cdc_fifo #(
  parameter int WIDTH   = 16,
  parameter int FIFO_AW = 4
) (
  input  logic             wr_clk,
  input  logic             rd_clk,
  input  logic             rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  output logic             full,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty
);

  localparam int DEPTH = 1 << FIFO_AW;

  logic [WIDTH-1:0] mem [DEPTH];

  // Pointers carry one extra bit to tell full from empty.
  logic [FIFO_AW:0] wr_bin;
  logic [FIFO_AW:0] wr_gray;
  logic [FIFO_AW:0] rd_bin;
  logic [FIFO_AW:0] rd_gray;
  logic [FIFO_AW:0] wr_bin_next;
  logic [FIFO_AW:0] rd_bin_next;

  // Synchronizer stages of the opposite Gray pointer.
  logic [FIFO_AW:0] rd_gray_w1;
  logic [FIFO_AW:0] rd_gray_w2;
  logic [FIFO_AW:0] wr_gray_r1;
  logic [FIFO_AW:0] wr_gray_r2;

  logic wr_go;
  logic rd_go;

  assign wr_go       = wr_en && !full;
  assign rd_go       = rd_en && !empty;
  assign wr_bin_next = wr_bin + 1'b1;
  assign rd_bin_next = rd_bin + 1'b1;

  // Write side.
  always_ff @(posedge wr_clk) begin
    if (wr_go) begin
      mem[wr_bin[FIFO_AW-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (rst) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
    end else begin
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
      if (wr_go) begin
        wr_bin  <= wr_bin_next;
        wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
      end
    end
  end

  // Full when the top two Gray bits differ and the rest match.
  assign full = (wr_gray == (rd_gray_w2 ^ {2'b11, {(FIFO_AW-1){1'b0}}}));

  // Read side.
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
    end else begin
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
      if (rd_go) begin
        rd_bin  <= rd_bin_next;
        rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
      end
    end
  end

  assign empty = (rd_gray == wr_gray_r2);

  // First word falls through.
  assign rd_data = mem[rd_bin[FIFO_AW-1:0]];

endmodule

/* verilog/iwdg_bus_slave.sv */
`timescale 1ns/100ps

module iwdg_bus_slave
  import iwdg_reg_pkg::*;
  import iwdg_link_pkg::*;
#(
  parameter logic [31:0] BASE_ADR = 32'h0100_0000
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             cyc_m2s,
  input  logic             stb_m2s,
  input  logic             we_m2s,
  input  logic [31:0]      adr_m2s,
  input  logic [KEY_W-1:0] dat_m2s,
  output logic [KEY_W-1:0] dat_s2m,
  output logic             ack_s2m,
  output logic [CMD_W-1:0] cmd_wdata,
  output logic             cmd_wr,
  input  logic             cmd_full,
  input  logic [RSP_W-1:0] rsp_rdata,
  output logic             rsp_rd,
  input  logic             rsp_empty
);

  bus_state_e       state;
  bus_state_e       state_next;
  logic [31:0]      ofs;
  logic             mapped;
  reg_sel_e         sel;
  link_op_e         op;
  logic [KEY_W-1:0] payload;

  // Offset of the access inside the slave window.
  assign ofs = adr_m2s - BASE_ADR;

  // Address decode into a register select.
  always_comb begin
    mapped = 1'b1;
    sel    = SEL_KR;
    case (ofs)
      KR_OFS:  sel = SEL_KR;
      PR_OFS:  sel = SEL_PR;
      RLR_OFS: sel = SEL_RLR;
      ST_OFS:  sel = SEL_ST;
      default: mapped = 1'b0;
    endcase
  end

  // Reads carry no payload.
  assign op        = we_m2s ? LINK_WR : LINK_RD;
  assign payload   = we_m2s ? dat_m2s : '0;
  assign cmd_wdata = {op, sel, payload};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= BUS_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    cmd_wr     = 1'b0;
    rsp_rd     = 1'b0;
    ack_s2m    = 1'b0;
    dat_s2m    = '0;
    case (state)
      BUS_IDLE: begin
        // A new bus cycle starts.
        if (cyc_m2s && stb_m2s) begin
          state_next = BUS_ISSUE;
        end
      end
      BUS_ISSUE: begin
        if (!mapped) begin
          // Unmapped access is answered here with zero data.
          ack_s2m    = 1'b1;
          state_next = BUS_IDLE;
        end else if (!cmd_full) begin
          cmd_wr     = 1'b1;
          state_next = BUS_WAIT;
        end
      end
      BUS_WAIT: begin
        // FWFT response word is valid as soon as the FIFO is not empty.
        if (!rsp_empty) begin
          rsp_rd     = 1'b1;
          ack_s2m    = 1'b1;
          state_next = BUS_IDLE;
          if (op == LINK_RD) begin
            dat_s2m = rsp_rdata;
          end
        end
      end
      default: begin
        state_next = BUS_IDLE;
      end
    endcase
  end

endmodule

/* verilog/iwdg_regs.sv */
`timescale 1ns/100ps

module iwdg_regs
  import iwdg_reg_pkg::*;
  import iwdg_link_pkg::*;
(
  input  logic             iwdg_clk,
  input  logic             rst,
  input  logic [CMD_W-1:0] cmd_rdata,
  input  logic             cmd_empty,
  output logic             cmd_rd,
  output logic [RSP_W-1:0] rsp_wdata,
  output logic             rsp_wr,
  output logic             count_en,
  output logic             reload,
  output logic [RLR_W-1:0] reload_val,
  output pr_code_e         pr_code
);

  iwdg_key_e        key;
  logic [RLR_W-1:0] rlr;
  pr_code_e         pr;
  logic [ST_W-1:0]  st;

  link_op_e         op;
  reg_sel_e         sel;
  logic [KEY_W-1:0] payload;
  logic             wr_cmd;

  // Fields of the command word at the FIFO head.
  assign op      = link_op_e'(cmd_rdata[CMD_OP_BIT]);
  assign sel     = reg_sel_e'(cmd_rdata[CMD_SEL_LSB +: 2]);
  assign payload = cmd_rdata[KEY_W-1:0];

  // One command per cycle, answered in the same cycle.
  assign cmd_rd = ~cmd_empty;
  assign rsp_wr = cmd_rd;
  assign wr_cmd = cmd_rd && (op == LINK_WR);

  always_ff @(posedge iwdg_clk) begin
    if (rst) begin
      key    <= KEY_IDLE;
      rlr    <= RLR_RESET;
      pr     <= PR_RESET;
      st     <= '0;
      reload <= 1'b0;
    end else begin
      reload <= 1'b0;
      if (wr_cmd) begin
        // Writes clear status unless they set it below.
        st <= '0;
        case (sel)
          SEL_KR: begin
            key <= iwdg_key_e'(payload);
            if (payload == KEY_RELOAD) begin
              st     <= 2'b10;
              reload <= 1'b1;
            end
          end
          SEL_PR: begin
            // Locked unless the access key is in place, code 7 is refused.
            if (key == KEY_ACCESS && payload[PR_W-1:0] != {PR_W{1'b1}}) begin
              pr <= pr_code_e'(payload[PR_W-1:0]);
              st <= 2'b01;
            end
          end
          SEL_RLR: begin
            if (key == KEY_ACCESS) begin
              rlr <= payload[RLR_W-1:0];
            end
          end
          SEL_ST: begin
            st <= payload[ST_W-1:0];
          end
          default: begin
            st <= '0;
          end
        endcase
      end
    end
  end

  // Response word.
  // Reads return the register zero-extended, writes return 1.
  always_comb begin
    rsp_wdata = RSP_W'(1);
    if (op == LINK_RD) begin
      case (sel)
        SEL_KR:  rsp_wdata = key;
        SEL_PR:  rsp_wdata = RSP_W'(pr);
        SEL_RLR: rsp_wdata = RSP_W'(rlr);
        SEL_ST:  rsp_wdata = RSP_W'(st);
        default: rsp_wdata = '0;
      endcase
    end
  end

  // Counter controls.
  assign count_en   = (key == KEY_COUNT);
  assign reload_val = rlr;
  assign pr_code    = pr;

endmodule

/* verilog/iwdg_counter.sv */
`timescale 1ns/100ps

module iwdg_counter
  import iwdg_reg_pkg::*;
(
  input  logic             iwdg_clk,
  input  logic             rst,
  input  logic             count_en,
  input  logic             reload,
  input  logic [RLR_W-1:0] reload_val,
  input  pr_code_e         pr_code,
  output logic             iwdg_rst
);

  logic [7:0]       pre_cnt;
  logic [7:0]       pre_last;
  logic             tick;
  logic [RLR_W-1:0] cnt;

  // Last prescaler value is 4 shifted by the code, minus one.
  assign pre_last = 8'((9'd4 << pr_code) - 9'd1);

  // Greater-or-equal so a smaller code mid-count still ticks at once.
  assign tick = count_en && (pre_cnt >= pre_last);

  always_ff @(posedge iwdg_clk) begin
    if (rst) begin
      pre_cnt  <= '0;
      cnt      <= RLR_RESET;
      iwdg_rst <= 1'b0;
    end else if (reload) begin
      // Restart the whole count from the reload value.
      pre_cnt  <= '0;
      cnt      <= reload_val;
      iwdg_rst <= 1'b0;
    end else if (count_en) begin
      if (tick) begin
        pre_cnt <= '0;
        // Counter parks at zero and holds the reset.
        if (cnt == '0) begin
          iwdg_rst <= 1'b1;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end else begin
        pre_cnt <= pre_cnt + 1'b1;
      end
    end
  end

endmodule

/* verilog/iwdg_top.sv */
`timescale 1ns/100ps

module iwdg_top
  import iwdg_reg_pkg::*;
  import iwdg_link_pkg::*;
#(
  parameter logic [31:0] BASE_ADR = 32'h0100_0000,
  parameter int          FIFO_AW  = 4
) (
  input  logic             clk,
  input  logic             iwdg_clk,
  input  logic             rst,
  input  logic             cyc_m2s,
  input  logic             stb_m2s,
  input  logic             we_m2s,
  input  logic [31:0]      adr_m2s,
  input  logic [KEY_W-1:0] dat_m2s,
  output logic [KEY_W-1:0] dat_s2m,
  output logic             ack_s2m,
  output logic             iwdg_rst
);

  // Command path, bus clock to watchdog clock.
  logic [CMD_W-1:0] cmd_wdata;
  logic             cmd_wr;
  logic             cmd_full;
  logic [CMD_W-1:0] cmd_rdata;
  logic             cmd_rd;
  logic             cmd_empty;

  // Response path, watchdog clock back to bus clock.
  logic [RSP_W-1:0] rsp_wdata;
  logic             rsp_wr;
  logic [RSP_W-1:0] rsp_rdata;
  logic             rsp_rd;
  logic             rsp_empty;

  // Register file to counter.
  logic             count_en;
  logic             reload;
  logic [RLR_W-1:0] reload_val;
  pr_code_e         pr_code;

  iwdg_bus_slave #(
    .BASE_ADR(BASE_ADR)
  ) bus_slave (
    .clk(clk),
    .rst(rst),
    .cyc_m2s(cyc_m2s),
    .stb_m2s(stb_m2s),
    .we_m2s(we_m2s),
    .adr_m2s(adr_m2s),
    .dat_m2s(dat_m2s),
    .dat_s2m(dat_s2m),
    .ack_s2m(ack_s2m),
    .cmd_wdata(cmd_wdata),
    .cmd_wr(cmd_wr),
    .cmd_full(cmd_full),
    .rsp_rdata(rsp_rdata),
    .rsp_rd(rsp_rd),
    .rsp_empty(rsp_empty)
  );

  iwdg_cdc_fifo #(
    .WIDTH(CMD_W),
    .FIFO_AW(FIFO_AW)
  ) cmd_fifo (
    .wr_clk(clk),
    .rd_clk(iwdg_clk),
    .rst(rst),
    .wr_en(cmd_wr),
    .wr_data(cmd_wdata),
    .full(cmd_full),
    .rd_en(cmd_rd),
    .rd_data(cmd_rdata),
    .empty(cmd_empty)
  );

  // One command in flight, so this FIFO never fills.
  iwdg_cdc_fifo #(
    .WIDTH(RSP_W),
    .FIFO_AW(FIFO_AW)
  ) rsp_fifo (
    .wr_clk(iwdg_clk),
    .rd_clk(clk),
    .rst(rst),
    .wr_en(rsp_wr),
    .wr_data(rsp_wdata),
    .full(),
    .rd_en(rsp_rd),
    .rd_data(rsp_rdata),
    .empty(rsp_empty)
  );

  iwdg_regs regs (
    .iwdg_clk(iwdg_clk),
    .rst(rst),
    .cmd_rdata(cmd_rdata),
    .cmd_empty(cmd_empty),
    .cmd_rd(cmd_rd),
    .rsp_wdata(rsp_wdata),
    .rsp_wr(rsp_wr),
    .count_en(count_en),
    .reload(reload),
    .reload_val(reload_val),
    .pr_code(pr_code)
  );

  iwdg_counter counter (
    .iwdg_clk(iwdg_clk),
    .rst(rst),
    .count_en(count_en),
    .reload(reload),
    .reload_val(reload_val),
    .pr_code(pr_code),
    .iwdg_rst(iwdg_rst)
  );

endmodule

/* testbench/iwdg_tb.sv */
`timescale 1ns/100ps

module iwdg_tb
  import iwdg_reg_pkg::*;
  import iwdg_link_pkg::*;
();

  // Bus cycles longer than this are treated as hung.
  localparam int ACK_TIMEOUT = 200;

  logic             clk;
  logic             iwdg_clk;
  logic             rst;
  logic             cyc_m2s;
  logic             stb_m2s;
  logic             we_m2s;
  logic [31:0]      adr_m2s;
  logic [KEY_W-1:0] dat_m2s;
  logic [KEY_W-1:0] dat_s2m;
  logic             ack_s2m;
  logic             iwdg_rst;

  int     data_errs;
  int     rst_errs;
  int     other_errs;
  integer seed;

  iwdg_top #(
    .BASE_ADR(32'h0100_0000),
    .FIFO_AW(4)
  ) uut (
    .clk(clk),
    .iwdg_clk(iwdg_clk),
    .rst(rst),
    .cyc_m2s(cyc_m2s),
    .stb_m2s(stb_m2s),
    .we_m2s(we_m2s),
    .adr_m2s(adr_m2s),
    .dat_m2s(dat_m2s),
    .dat_s2m(dat_s2m),
    .ack_s2m(ack_s2m),
    .iwdg_rst(iwdg_rst)
  );

  // Bus clock with a 20 ns period.
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog clock with a 30 ns period so that reset spans one of its edges.
  initial begin
    iwdg_clk = 1'b0;
    forever #15 iwdg_clk = ~iwdg_clk;
  end

  task automatic check_data(input logic [KEY_W-1:0] got, input logic [KEY_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s returned %h, expected %h", $time, what, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_rst(input logic got, input logic exp, input time at, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s, iwdg_rst is %0b, expected %0b", at, what, got, exp);
      rst_errs++;
    end
  endtask

  // One Wishbone classic cycle; inputs change 2 ns after the clk edge.
  task automatic bus_cycle(input logic we, input logic [31:0] adr,
                           input logic [KEY_W-1:0] dat,
                           output logic [KEY_W-1:0] rdata, output bit acked);
    int n;
    n     = 0;
    acked = 1'b0;
    rdata = '0;
    @(posedge clk);
    #2;
    cyc_m2s = 1'b1;
    stb_m2s = 1'b1;
    we_m2s  = we;
    adr_m2s = adr;
    dat_m2s = dat;
    // Ack is a one-cycle pulse and is sampled mid-cycle.
    while (!acked && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
      if (ack_s2m) begin
        acked = 1'b1;
        rdata = dat_s2m;
      end
    end
    @(posedge clk);
    #2;
    cyc_m2s = 1'b0;
    stb_m2s = 1'b0;
    we_m2s  = 1'b0;
    if (!acked) begin
      $display("No ack from the bus slave for address %h after %0d cycles", adr, ACK_TIMEOUT);
      other_errs++;
    end
  endtask

  // iwdg_rst must stay low for lower cycles and rise by upper.
  task automatic watch_rst(input int lower, input int upper);
    int n;
    bit rose;
    n    = 0;
    rose = 1'b0;
    while (!rose && n < upper) begin
      @(negedge iwdg_clk);
      n++;
      if (iwdg_rst !== 1'b0) begin
        rose = 1'b1;
        if (n <= lower) begin
          check_rst(iwdg_rst, 1'b0, $time, $sformatf("early rise after %0d cycles", n));
        end else begin
          check_rst(iwdg_rst, 1'b1, $time, $sformatf("rise after %0d cycles", n));
        end
      end
    end
    if (!rose) begin
      check_rst(iwdg_rst, 1'b1, $time, $sformatf("no rise within %0d cycles", upper));
    end
  endtask

  // Idle while iwdg_rst holds its expected level; stops at the first miss.
  task automatic idle_check(input int cycles, input logic exp);
    int n;
    bit ok;
    n  = 0;
    ok = 1'b1;
    while (ok && n < cycles) begin
      @(negedge iwdg_clk);
      n++;
      if (iwdg_rst !== exp) begin
        ok = 1'b0;
        check_rst(iwdg_rst, exp, $time, "idle period");
      end
    end
  endtask

  // Decode and run one line of the test file.
  task automatic run_line(input string text);
    byte              kind;
    logic [31:0]      adr;
    logic [31:0]      dat;
    logic [31:0]      exp_val;
    logic [KEY_W-1:0] wdata;
    logic [KEY_W-1:0] rdata;
    bit               acked;
    int               fields;
    fields = $sscanf(text, "%c %h %h %h", kind, adr, dat, exp_val);
    if (fields < 4) begin
      $display("Malformed line in the test file: %s", text);
      other_errs++;
    end else begin
      case (kind)
        "W": begin
          // Flag 1 asks for random data.
          wdata = (exp_val == 1) ? KEY_W'($random(seed)) : dat[KEY_W-1:0];
          bus_cycle(1'b1, adr, wdata, rdata, acked);
          // Writes return zero data.
          if (acked) begin
            check_data(rdata, '0, $sformatf("write to %h", adr));
          end
        end
        "R": begin
          bus_cycle(1'b0, adr, '0, rdata, acked);
          if (acked) begin
            check_data(rdata, exp_val[KEY_W-1:0], $sformatf("read of %h", adr));
          end
        end
        "T": watch_rst(dat, exp_val);
        "Q": idle_check(dat, exp_val[0]);
        default: begin
          $display("Unknown operation kind in the test file: %s", text);
          other_errs++;
        end
      endcase
    end
  endtask

  initial begin : run_tests
    integer fd;
    string  text;
    int     code;
    seed       = 32'h5b81f4ce;
    data_errs  = 0;
    rst_errs   = 0;
    other_errs = 0;
    rst        = 1'b1;
    cyc_m2s    = 1'b0;
    stb_m2s    = 1'b0;
    we_m2s     = 1'b0;
    adr_m2s    = '0;
    dat_m2s    = '0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    fd = $fopen("testbench/iwdg_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test file testbench/iwdg_tests.txt");
      other_errs++;
    end else begin
      while (!$feof(fd)) begin
        text = "";
        code = $fgets(text, fd);
        // Skip blank lines and comment lines.
        if (code != 0 && text.len() > 1 && text.getc(0) != "#") begin
          run_line(text);
        end
      end
      $fclose(fd);
    end
    $display("Errors: data %0d, reset %0d, other %0d", data_errs, rst_errs, other_errs);
    if (data_errs + rst_errs + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* testbench/iwdg_tests.txt */
# kind addr data exp. W writes data, exp 1 means random data. R reads and compares with exp.
# T needs iwdg_rst low for data iwdg_clk cycles and high by exp. Q idles data cycles at level exp.
R 01000000 0000 0000
R 01000004 0000 0000
R 01000008 0000 0FFF
R 0100000C 0000 0000
W 01000008 0000 00000001
R 01000008 0000 0FFF
W 01000004 0000 00000001
R 01000004 0000 0000
W 01000000 5555 0
W 01000008 0123 0
R 01000008 0000 0123
W 01000004 0003 0
R 0100000C 0000 0001
R 01000004 0000 0003
W 01000004 0007 0
R 01000004 0000 0003
R 0100000C 0000 0000
R 01000000 0000 5555
W 01000000 AAAA 0
R 0100000C 0000 0002
W 0100000C 0007 0
R 0100000C 0000 0003
W 01000010 1234 0
R 01000010 0000 0000
R 0100000C 0000 0003
# Reload 5 at divide by 4, then count.
W 01000000 5555 0
W 01000008 0005 0
W 01000004 0000 0
W 01000000 AAAA 0
W 01000000 CCCC 0
T 00000000 0014 002C
W 01000000 AAAA 0
Q 00000000 000A 0
# Kick the watchdog before it expires.
W 01000000 CCCC 0
Q 00000000 0008 0
W 01000000 AAAA 0
W 01000000 CCCC 0
Q 00000000 0008 0
W 01000000 AAAA 0
W 01000000 CCCC 0
Q 00000000 0008 0
W 01000000 AAAA 0
Q 00000000 0028 0
# Reload 3 at divide by 8.
W 01000000 5555 0
W 01000004 0001 0
W 01000008 0003 0
W 01000000 AAAA 0
W 01000000 CCCC 0
T 00000000 0018 0034
W 01000000 AAAA 0
Q 00000000 000A 0

/* filelist.f */
verilog/iwdg_reg_pkg.sv
verilog/iwdg_link_pkg.sv
verilog/iwdg_cdc_fifo.sv
verilog/iwdg_bus_slave.sv
verilog/iwdg_regs.sv
verilog/iwdg_counter.sv
verilog/iwdg_top.sv
testbench/iwdg_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = iwdg_tb
FILELIST  = filelist.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
